// File: mipsIsaPkg.sv
// ##############################
// MIPS instruction set package
// Word and field widths, opcode and funct codes
// ##############################

package mipsIsaPkg;

    localparam int insnWidth    = 32;
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int immWidth     = 16; // I-type immediate field

    // Primary opcode, insn[31:26]
    typedef enum logic [5:0]
    {
        opSpecial = 6'b000000, // R-type, op selected by funct
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opOri     = 6'b001101,
        opLui     = 6'b001111
    } opcodeT;

    // Function field of SPECIAL, insn[5:0]
    typedef enum logic [5:0]
    {
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnSlt  = 6'b101010
    } functT;

endpackage

// File: pipeCtrlPkg.sv
// ##############################
// Pipeline control package
// ALU operation codes, register file size
// ##############################

package pipeCtrlPkg;

    // Operation carried from decode to execute
    typedef enum logic [2:0]
    {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt, // Signed compare
        aluLui  // Immediate into upper half
    } aluOpT;

    localparam int regCount = 32;

    // Hard-wired zero register
    localparam logic [4:0] zeroReg = 5'd0;

endpackage

// File: registerFile.sv
// ##############################
// Register file, 32 x 32 bits
// Two combinational reads with write-through, one write
// ##############################

`timescale 1ns/1ps

module registerFile
    import mipsIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [regAddrWidth-1:0] rsAddr,
    input  logic [regAddrWidth-1:0] rtAddr,
    output logic [dataWidth-1:0]    rsData,
    output logic [dataWidth-1:0]    rtData,
    input  logic                    wbWe,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [dataWidth-1:0]    wbData
);

    logic [dataWidth-1:0] regs [regCount];
    logic                 wrLive; // A write to a real register this cycle

    assign wrLive = wbWe && (wbAddr != zeroReg);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < regCount; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wrLive)
        begin
            regs[wbAddr] <= wbData;
        end
    end

    // Pending write wins over the stored value
    assign rsData = (wrLive && (wbAddr == rsAddr)) ? wbData : regs[rsAddr];
    assign rtData = (wrLive && (wbAddr == rtAddr)) ? wbData : regs[rtAddr];

    zeroRegStaysZero : assert property (
        @(posedge clock) disable iff (reset) regs[zeroReg] == '0
    );

endmodule

// File: decodeStage.sv
// ##############################
// Decode stage
// Splits the instruction, reads operands, registers control
// ##############################

`timescale 1ns/1ps

module decodeStage
    import mipsIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [insnWidth-1:0]    insn,
    input  logic                    insnValid,
    output logic [regAddrWidth-1:0] rsAddr,
    output logic [regAddrWidth-1:0] rtAddr,
    input  logic [dataWidth-1:0]    rsData,
    input  logic [dataWidth-1:0]    rtData,
    output logic                    decValid,
    output aluOpT                   decAluOp,
    output logic [regAddrWidth-1:0] decDest,
    output logic                    decWe,
    output logic                    decIllegal,
    output logic [regAddrWidth-1:0] decRsAddr,
    output logic [regAddrWidth-1:0] decRtAddr,
    output logic [dataWidth-1:0]    decOpA,
    output logic [dataWidth-1:0]    decOpB,
    output logic                    decUseImm
);

    opcodeT                  opcode;
    functT                   funct;
    logic [regAddrWidth-1:0] rd;
    logic [immWidth-1:0]     imm;
    logic [dataWidth-1:0]    immSext;
    logic [dataWidth-1:0]    immZext;

    aluOpT                   aluOpNext;
    logic [regAddrWidth-1:0] destNext;
    logic [dataWidth-1:0]    immNext;
    logic                    useImmNext;
    logic                    illegalNext;

    assign opcode = opcodeT'(insn[31:26]);
    assign rsAddr = insn[25:21];
    assign rtAddr = insn[20:16];
    assign rd     = insn[15:11];
    assign funct  = functT'(insn[5:0]);
    assign imm    = insn[immWidth-1:0];

    assign immSext = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
    assign immZext = {{(dataWidth-immWidth){1'b0}}, imm};

    always_comb
    begin
        aluOpNext   = aluAdd;
        destNext    = rtAddr;  // I-types write rt
        immNext     = immSext;
        useImmNext  = 1'b1;
        illegalNext = 1'b0;
        case (opcode)
            opSpecial:
            begin
                destNext   = rd;
                useImmNext = 1'b0;
                case (funct)
                    fnAddu:  aluOpNext = aluAdd;
                    fnSubu:  aluOpNext = aluSub;
                    fnAnd:   aluOpNext = aluAnd;
                    fnOr:    aluOpNext = aluOr;
                    fnSlt:   aluOpNext = aluSlt;
                    default: illegalNext = 1'b1;
                endcase
            end
            opAddiu: aluOpNext = aluAdd;
            opSlti:  aluOpNext = aluSlt;
            opOri:
            begin
                aluOpNext = aluOr;
                immNext   = immZext;
            end
            opLui:
            begin
                aluOpNext = aluLui;
                immNext   = immZext; // Shifted up in execute
            end
            default: illegalNext = 1'b1;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            decValid   <= 1'b0;
            decWe      <= 1'b0;
            decIllegal <= 1'b0;
        end
        else
        begin
            decValid   <= insnValid;
            decWe      <= insnValid && !illegalNext;
            decIllegal <= insnValid && illegalNext;
        end
    end

    // Payload, meaningful only with decValid
    always_ff @(posedge clock)
    begin
        decAluOp  <= aluOpNext;
        decDest   <= destNext;
        decRsAddr <= rsAddr;
        decRtAddr <= rtAddr;
        decOpA    <= rsData;
        decOpB    <= useImmNext ? immNext : rtData;
        decUseImm <= useImmNext;
    end

    illegalNeverWrites : assert property (
        @(posedge clock) disable iff (reset) !(decIllegal && decWe)
    );

endmodule

// File: executeStage.sv
// ##############################
// Execute stage
// ALU with self-forwarding, result and write-back registers
// ##############################

`timescale 1ns/1ps

module executeStage
    import mipsIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    decValid,
    input  aluOpT                   decAluOp,
    input  logic [regAddrWidth-1:0] decDest,
    input  logic                    decWe,
    input  logic                    decIllegal,
    input  logic [regAddrWidth-1:0] decRsAddr,
    input  logic [regAddrWidth-1:0] decRtAddr,
    input  logic [dataWidth-1:0]    decOpA,
    input  logic [dataWidth-1:0]    decOpB,
    input  logic                    decUseImm,
    output logic                    resultValid,
    output logic                    illegal,
    output logic                    wbWe,
    output logic [regAddrWidth-1:0] wbAddr,
    output logic [dataWidth-1:0]    wbData
);

    logic                 fwdOk;
    logic                 fwdA;
    logic                 fwdB;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;

    // Previous instruction still sits in the result register
    assign fwdOk = wbWe && (wbAddr != zeroReg);
    assign fwdA  = fwdOk && (decRsAddr == wbAddr);
    assign fwdB  = fwdOk && !decUseImm && (decRtAddr == wbAddr);

    assign opA = fwdA ? wbData : decOpA;
    assign opB = fwdB ? wbData : decOpB;

    always_comb
    begin
        case (decAluOp)
            aluAdd:  aluResult = opA + opB;
            aluSub:  aluResult = opA - opB;
            aluAnd:  aluResult = opA & opB;
            aluOr:   aluResult = opA | opB;
            aluSlt:
            begin
                aluResult = '0;
                aluResult[0] = $signed(opA) < $signed(opB);
            end
            aluLui:  aluResult = {opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
            wbWe        <= 1'b0;
        end
        else
        begin
            resultValid <= decValid;
            illegal     <= decValid && decIllegal;
            wbWe        <= decValid && decWe;
        end
    end

    always_ff @(posedge clock)
    begin
        wbAddr <= decDest;
        wbData <= aluResult;
    end

    writeNeedsValid : assert property (
        @(posedge clock) disable iff (reset) wbWe |-> resultValid
    );

endmodule

// File: mipsCoreTop.sv
// ##############################
// Core slice top level
// Decode, register file and execute
// ##############################

`timescale 1ns/1ps

module mipsCoreTop
    import mipsIsaPkg::*, pipeCtrlPkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [insnWidth-1:0]    insn,
    input  logic                    insnValid,
    output logic                    resultValid,
    output logic [regAddrWidth-1:0] resultReg,
    output logic [dataWidth-1:0]    resultData,
    output logic                    illegal
);

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rsData;
    logic [dataWidth-1:0]    rtData;

    logic                    decValid;
    aluOpT                   decAluOp;
    logic [regAddrWidth-1:0] decDest;
    logic                    decWe;
    logic                    decIllegal;
    logic [regAddrWidth-1:0] decRsAddr;
    logic [regAddrWidth-1:0] decRtAddr;
    logic [dataWidth-1:0]    decOpA;
    logic [dataWidth-1:0]    decOpB;
    logic                    decUseImm;

    logic                    wbWe;
    logic [regAddrWidth-1:0] wbAddr;
    logic [dataWidth-1:0]    wbData;

    decodeStage decode0 (
        .clock      (clock),
        .reset      (reset),
        .insn       (insn),
        .insnValid  (insnValid),
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rsData     (rsData),
        .rtData     (rtData),
        .decValid   (decValid),
        .decAluOp   (decAluOp),
        .decDest    (decDest),
        .decWe      (decWe),
        .decIllegal (decIllegal),
        .decRsAddr  (decRsAddr),
        .decRtAddr  (decRtAddr),
        .decOpA     (decOpA),
        .decOpB     (decOpB),
        .decUseImm  (decUseImm)
    );

    registerFile regFile0 (
        .clock  (clock),
        .reset  (reset),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .wbWe   (wbWe),
        .wbAddr (wbAddr),
        .wbData (wbData)
    );

    executeStage execute0 (
        .clock       (clock),
        .reset       (reset),
        .decValid    (decValid),
        .decAluOp    (decAluOp),
        .decDest     (decDest),
        .decWe       (decWe),
        .decIllegal  (decIllegal),
        .decRsAddr   (decRsAddr),
        .decRtAddr   (decRtAddr),
        .decOpA      (decOpA),
        .decOpB      (decOpB),
        .decUseImm   (decUseImm),
        .resultValid (resultValid),
        .illegal     (illegal),
        .wbWe        (wbWe),
        .wbAddr      (wbAddr),
        .wbData      (wbData)
    );

    // Reported result is the write-back word
    assign resultReg  = wbAddr;
    assign resultData = wbData;

endmodule

// File: tbMipsCore.sv
// ##############################
// Testbench for the core slice
// Directed and random instruction streams against a reference model
// ##############################

`timescale 1ns/1ps

module tbMipsCore
    import mipsIsaPkg::*, pipeCtrlPkg::*;
;

    localparam int clockPeriod = 4;
    localparam int streamLen   = 400;
    localparam int fixedInsns  = 320;  // Tests 1 to 5 with drains, rounded up
    // Stream may idle once per instruction
    localparam int watchdogNs  = (fixedInsns + 2 * streamLen) * clockPeriod + 400;

    typedef struct packed
    {
        logic [regAddrWidth-1:0] dest;
        logic [dataWidth-1:0]    data;
        logic                    we;
        logic                    ill;
        int                      due;  // Cycle in which resultValid is expected
    } expT;

    logic                    clock = 1'b0;
    logic                    reset;
    logic [insnWidth-1:0]    insn;
    logic                    insnValid;
    logic                    resultValid;
    logic [regAddrWidth-1:0] resultReg;
    logic [dataWidth-1:0]    resultData;
    logic                    illegal;

    logic [dataWidth-1:0] modelRegs [regCount];
    logic [31:0]          lcgState = 32'd87312;
    expT                  expQ [$];
    int                   cycleCount   = 0;
    int                   errorCount   = 0;
    int                   checkCount   = 0;
    int                   testsRun     = 0;
    int                   testsBad     = 0;
    int                   testErrStart = 0;

    mipsCoreTop dut0 (
        .clock       (clock),
        .reset       (reset),
        .insn        (insn),
        .insnValid   (insnValid),
        .resultValid (resultValid),
        .resultReg   (resultReg),
        .resultData  (resultData),
        .illegal     (illegal)
    );

    always #(clockPeriod / 2) clock = ~clock;

    always @(posedge clock) cycleCount <= cycleCount + 1;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic [regAddrWidth-1:0] randReg();
        logic [31:0] r;
        r = nextRand();
        return r[27:23];
    endfunction

    function automatic logic [15:0] randImm();
        logic [31:0] r;
        r = nextRand();
        return r[31:16];
    endfunction

    function automatic logic [insnWidth-1:0] rType(input logic [5:0] fn,
        input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd);
        return {opSpecial, rs, rt, rd, 5'b00000, fn};
    endfunction

    function automatic logic [insnWidth-1:0] iType(input logic [5:0] op,
        input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] badOpcode();
        logic [31:0] r;
        logic [5:0]  op;
        op = opSpecial;
        while (op == opSpecial || op == opAddiu || op == opSlti || op == opOri || op == opLui)
        begin
            r  = nextRand();
            op = r[29:24];
        end
        return op;
    endfunction

    function automatic logic [5:0] badFunct();
        logic [31:0] r;
        logic [5:0]  fn;
        fn = fnAddu;
        while (fn == fnAddu || fn == fnSubu || fn == fnAnd || fn == fnOr || fn == fnSlt)
        begin
            r  = nextRand();
            fn = r[29:24];
        end
        return fn;
    endfunction

    // Expected response of one instruction, applied to the model registers
    function automatic expT refExecute(input logic [insnWidth-1:0] word);
        expT                  e;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] sext;
        logic [15:0]          imm;
        imm    = word[15:0];
        sext   = {{16{imm[15]}}, imm};
        a      = modelRegs[word[25:21]];
        b      = modelRegs[word[20:16]];
        e.dest = word[20:16];
        e.data = '0;
        e.ill  = 1'b0;
        e.due  = cycleCount + 2;  // Called while the strobe is presented
        case (word[31:26])
            opSpecial:
            begin
                e.dest = word[15:11];
                case (word[5:0])
                    fnAddu:  e.data = a + b;
                    fnSubu:  e.data = a - b;
                    fnAnd:   e.data = a & b;
                    fnOr:    e.data = a | b;
                    fnSlt:   e.data = {31'd0, $signed(a) < $signed(b)};
                    default: e.ill = 1'b1;
                endcase
            end
            opAddiu: e.data = a + sext;
            opSlti:  e.data = {31'd0, $signed(a) < $signed(sext)};
            opOri:   e.data = a | {16'd0, imm};
            opLui:   e.data = {imm, 16'd0};
            default: e.ill = 1'b1;
        endcase
        e.we = !e.ill;
        if (e.we && e.dest != zeroReg)
        begin
            modelRegs[e.dest] = e.data;  // Register 0 never changes
        end
        return e;
    endfunction

    function automatic logic [insnWidth-1:0] randomInsn();
        logic [31:0]             r;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
        logic [insnWidth-1:0]    word;
        r  = nextRand();
        rs = {1'b0, r[27:24]};  // Low registers only, so dependencies are frequent
        rt = {1'b0, r[23:20]};
        rd = {1'b0, r[19:16]};
        case (r[31:28])
            4'd0:    word = rType(fnAddu, rs, rt, rd);
            4'd1:    word = rType(fnSubu, rs, rt, rd);
            4'd2:    word = rType(fnAnd, rs, rt, rd);
            4'd3:    word = rType(fnOr, rs, rt, rd);
            4'd4:    word = rType(fnSlt, rs, rt, rd);
            4'd5:    word = iType(opAddiu, rs, rt, randImm());
            4'd6:    word = iType(opSlti, rs, rt, randImm());
            4'd7:    word = iType(opOri, rs, rt, randImm());
            4'd8:    word = iType(opLui, rs, rt, randImm());
            4'd9:    word = rType(badFunct(), rs, rt, rd);
            4'd10:   word = iType(badOpcode(), rs, rt, randImm());
            4'd11:   word = rType(fnSubu, rs, rt, rd);
            default: word = iType(opAddiu, rs, rt, randImm());
        endcase
        return word;
    endfunction

    task automatic checkData(input string name, input logic [dataWidth-1:0] expected,
        input logic [dataWidth-1:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkReg(input string name, input logic [regAddrWidth-1:0] expected,
        input logic [regAddrWidth-1:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("ERR t=%0t %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    // Outputs are sampled half a cycle after the edge
    always @(negedge clock)
    begin
        expT e;
        if (!reset)
        begin
            if (expQ.size() != 0 && expQ[0].due < cycleCount)
            begin
                e = expQ.pop_front();
                errorCount++;
                $display("t=%0t no result for the instruction due in cycle %0d", $time, e.due);
            end
            if (resultValid)
            begin
                if (expQ.size() == 0)
                begin
                    errorCount++;
                    $display("t=%0t result arrived with no instruction outstanding", $time);
                end
                else
                begin
                    e = expQ.pop_front();
                    if (e.due != cycleCount)
                    begin
                        errorCount++;
                        $display("t=%0t result in cycle %0d, expected in cycle %0d",
                            $time, cycleCount, e.due);
                    end
                    checkFlag("illegal", e.ill, illegal);
                    if (!e.ill)
                    begin
                        checkReg("resultReg", e.dest, resultReg);
                        checkData("resultData", e.data, resultData);
                    end
                end
            end
            else if (illegal)
            begin
                errorCount++;
                $display("t=%0t illegal raised without resultValid", $time);
            end
        end
    end

    task automatic issue(input logic [insnWidth-1:0] word);
        insn      = word;
        insnValid = 1'b1;
        expQ.push_back(refExecute(word));
        @(posedge clock);
        #1;
        insnValid = 1'b0;
    endtask

    task automatic idle();
        @(posedge clock);
        #1;
    endtask

    // OR each register with itself, which reports its value
    task automatic readAll();
        for (int i = 0; i < regCount; i++)
        begin
            issue(rType(fnOr, 5'(i), 5'(i), 5'(i)));
        end
    endtask

    task automatic beginTest();
        testErrStart = errorCount;
    endtask

    task automatic endTest(input string name);
        int    errs;
        string verdict;
        while (expQ.size() != 0)
        begin
            idle();
        end
        repeat (2) idle();  // Catch stray results
        errs = errorCount - testErrStart;
        testsRun++;
        verdict = "ok";
        if (errs != 0)
        begin
            testsBad++;
            verdict = "FAIL";
        end
        $display("test %0d %s: %s, %0d errors", testsRun, name, verdict, errs);
    endtask

    task automatic testResetOri();
        beginTest();
        readAll();
        for (int i = 1; i < regCount; i++)
        begin
            issue(iType(opOri, zeroReg, 5'(i), randImm()));
        end
        endTest("reset and ORI");
    endtask

    task automatic testRType();
        beginTest();
        for (int i = 1; i < regCount; i++)
        begin
            issue(iType(opLui, zeroReg, 5'(i), randImm()));  // Upper half gives both signs
            issue(iType(opOri, 5'(i), 5'(i), randImm()));
        end
        for (int k = 0; k < 8; k++)
        begin
            issue(rType(fnAddu, randReg(), randReg(), randReg()));
            issue(rType(fnSubu, randReg(), randReg(), randReg()));
            issue(rType(fnAnd, randReg(), randReg(), randReg()));
            issue(rType(fnOr, randReg(), randReg(), randReg()));
            issue(rType(fnSlt, randReg(), randReg(), randReg()));
        end
        endTest("R-type ALU");
    endtask

    task automatic testIType();
        beginTest();
        for (int k = 0; k < 8; k++)
        begin
            issue(iType(opAddiu, randReg(), randReg(), randImm()));
            issue(iType(opSlti, randReg(), randReg(), randImm()));
            issue(iType(opOri, randReg(), randReg(), randImm()));
            issue(iType(opLui, randReg(), randReg(), randImm()));
        end
        endTest("I-type immediates");
    endtask

    task automatic testDependencies();
        beginTest();
        repeat (6) issue(iType(opAddiu, 5'd5, 5'd5, 16'd1));  // Distance one
        repeat (4)
        begin
            issue(iType(opAddiu, 5'd6, 5'd6, 16'd3));  // Distance two
            issue(iType(opAddiu, 5'd7, 5'd7, 16'hfffb));
        end
        repeat (4) issue(rType(fnAddu, 5'd9, 5'd8, 5'd8));  // Forwarded through rt
        issue(iType(opLui, zeroReg, 5'd11, 16'h8001));
        issue(iType(opOri, 5'd11, 5'd11, 16'h00ff));
        issue(rType(fnSubu, 5'd11, 5'd11, 5'd12));
        // rt names the previous destination but the immediate must win
        issue(iType(opAddiu, 5'd2, 5'd13, 16'd100));
        issue(iType(opOri, 5'd2, 5'd13, 16'h00ff));
        endTest("dependencies");
    endtask

    task automatic testIllegalAndZero();
        beginTest();
        repeat (8) issue(iType(badOpcode(), randReg(), randReg(), randImm()));
        repeat (8) issue(rType(badFunct(), randReg(), randReg(), randReg()));
        readAll();
        issue(iType(opAddiu, 5'd1, zeroReg, randImm()));
        issue(rType(fnAddu, zeroReg, zeroReg, 5'd3));  // No forwarding from register 0
        issue(iType(opLui, zeroReg, zeroReg, randImm()));
        issue(iType(opOri, 5'd4, zeroReg, 16'h5a5a));
        issue(rType(fnOr, zeroReg, zeroReg, 5'd2));
        issue(rType(fnSubu, 5'd1, zeroReg, 5'd10));
        endTest("illegal and r0");
    endtask

    task automatic testRandomStream();
        logic [31:0] r;
        beginTest();
        for (int n = 0; n < streamLen; n++)
        begin
            r = nextRand();
            if (r[31:30] == 2'b00)
            begin
                idle();  // Gap in insnValid
            end
            issue(randomInsn());
        end
        endTest("random stream");
    endtask

    initial
    begin
        insn      = '0;
        insnValid = 1'b0;
        reset     = 1'b1;
        for (int i = 0; i < regCount; i++)
        begin
            modelRegs[i] = '0;
        end
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        testResetOri();
        testRType();
        testIType();
        testDependencies();
        testIllegalAndZero();
        testRandomStream();

        $display("%0d tests run, %0d with errors, %0d checks, %0d errors",
            testsRun, testsBad, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    initial
    begin
        #(watchdogNs);
        $display("watchdog expired after %0d ns, %0d results outstanding",
            watchdogNs, expQ.size());
        $display("tests failed");
        $finish;
    end

endmodule

// File: src.f
mipsIsaPkg.sv
pipeCtrlPkg.sv
registerFile.sv
decodeStage.sv
executeStage.sv
mipsCoreTop.sv
tbMipsCore.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the core slice testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbMipsCore -f src.f -o simMipsCore
output="$(./obj_dir/simMipsCore)"
echo "$output"

if grep -qx "all tests passed" <<< "$output"
then
    exit 0
fi
exit 1
